// File: flist.f
logic/usb_tx_pkg.sv
logic/usb_encoder.sv
logic/usb_tx_packet.sv
logic/usb_tx.sv
testbench/tb_usb_tx.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert --top-module tb_usb_tx -f flist.f -o sim_usb_tx \
	&& ./obj_dir/sim_usb_tx | tee /dev/stderr | grep -q "Done: no errors" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: testbench/tb_usb_tx.sv
// Directed testbench for the USB transmit line path with a line symbol model
`timescale 1ns/100ps

module tb_usb_tx;
	import usb_tx_pkg::*;

	logic                  tb_clk;
	logic                  arst_n;
	logic [byte_width-1:0] tx_byte;
	logic                  tx_load;
	logic                  tx_last;
	logic                  tx_empty;
	logic                  tx_busy;
	logic                  d_plus_out;
	logic                  d_minus_out;

	// Bytes of the packet under test, first byte first
	logic [byte_width-1:0] pkt_bytes[$];
	// Expected line symbols as {D+, D-}
	logic [1:0] exp_syms[$];
	// Expected tx_empty just after each symbol's strobe
	logic exp_empty[$];
	logic [31:0] lfsr_state;
	string test_name;
	int errors;
	int timeouts;

	usb_tx UUT
	(
		.tb_clk      (tb_clk),
		.arst_n      (arst_n),
		.tx_byte     (tx_byte),
		.tx_load     (tx_load),
		.tx_last     (tx_last),
		.tx_empty    (tx_empty),
		.tx_busy     (tx_busy),
		.d_plus_out  (d_plus_out),
		.d_minus_out (d_minus_out)
	);

	// 10 ns period
	always #5 tb_clk = ~tb_clk;

	// Taps 32, 22, 2, 1
	function logic [31:0] lfsr_next(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	// One LFSR step per bit taken
	task random_byte(output logic [byte_width-1:0] value);
		int i;
		for (i = 0; i < byte_width; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value[i] = lfsr_state[0];
		end
	endtask

	task check_line(input logic exp_dp, input logic exp_dm);
		if ({d_plus_out, d_minus_out} !== {exp_dp, exp_dm})
		begin
			$display("Fail %s {d_plus_out,d_minus_out}: expected %h, received %h",
				test_name, {exp_dp, exp_dm}, {d_plus_out, d_minus_out});
			errors++;
		end
	endtask

	task check_level(input string name, input logic expected);
		logic received;
		if (name == "tx_empty")
			received = tx_empty;
		else if (name == "tx_busy")
			received = tx_busy;
		else
			received = 1'bx;
		if (received !== expected)
		begin
			$display("Fail %s %s: expected %h, received %h", test_name, name, expected, received);
			errors++;
		end
	endtask

	// Reference symbols: LSB first, stuffing, NRZI from J, then EOP
	task build_expected;
		logic level;
		logic data;
		int ones;
		int b;
		int i;
		exp_syms.delete();
		exp_empty.delete();
		level = 1'b1;
		ones = 0;
		for (b = 0; b < pkt_bytes.size(); b++)
		begin
			for (i = 0; i < byte_width; i++)
			begin
				data = pkt_bytes[b][i];
				// Zero toggles
				if (!data)
					level = !level;
				exp_syms.push_back({level, !level});
				// Buffer opens once the last bit of a non-final byte is taken
				exp_empty.push_back(i == byte_width - 1 && b != pkt_bytes.size() - 1);
				ones = data ? ones + 1 : 0;
				// Run counts across byte boundaries
				if (ones == stuff_run)
				begin
					level = !level;
					exp_syms.push_back({level, !level});
					exp_empty.push_back(1'b0);
					ones = 0;
				end
			end
		end
		repeat (eop_se0_bits)
		begin
			exp_syms.push_back(2'b00);
			exp_empty.push_back(1'b0);
		end
		exp_syms.push_back(2'b10);
		exp_empty.push_back(1'b0);
	endtask

	task apply_reset;
		@(posedge tb_clk);
		#1;
		tx_load = 1'b0;
		arst_n = 1'b0;
		repeat (3)
			@(posedge tb_clk);
		#1;
		arst_n = 1'b1;
	endtask

	task drive_byte(input int idx);
		tx_byte = pkt_bytes[idx];
		tx_last = (idx == pkt_bytes.size() - 1);
		tx_load = 1'b1;
	endtask

	// Sends pkt_bytes and compares each line symbol in the clock it appears
	task run_packet;
		int cyc;
		int sym_idx;
		int byte_idx;
		int first_sample;
		logic [1:0] sym;
		build_expected();
		// Line changes bit_clocks+1 clocks after the load is driven
		first_sample = bit_clocks + 1;
		@(posedge tb_clk);
		#1;
		drive_byte(0);
		byte_idx = 1;
		cyc = 0;
		sym_idx = 0;
		while (sym_idx < exp_syms.size())
		begin
			@(posedge tb_clk);
			#1;
			cyc++;
			tx_load = 1'b0;
			if (cyc == 1)
			begin
				check_level("tx_busy", 1'b1);
				check_level("tx_empty", 1'b0);
			end
			// Next byte as soon as the buffer is empty
			if (tx_empty && byte_idx < pkt_bytes.size())
			begin
				drive_byte(byte_idx);
				byte_idx++;
			end
			if (cyc >= first_sample && (cyc - first_sample) % bit_clocks == 0)
			begin
				sym = exp_syms[sym_idx];
				check_line(sym[1], sym[0]);
				check_level("tx_empty", exp_empty[sym_idx]);
				sym_idx++;
			end
		end
		if (byte_idx < pkt_bytes.size())
		begin
			$display("%s: packet ended before all bytes were loaded", test_name);
			errors++;
		end
		wait_not_busy();
		check_level("tx_empty", 1'b1);
		// Line rests at J after the packet
		repeat (2)
		begin
			repeat (bit_clocks)
				@(posedge tb_clk);
			#1;
			check_line(1'b1, 1'b0);
		end
	endtask

	// Called as the closing J appears, busy drops one clock after that J ends
	task wait_not_busy;
		int count;
		count = 0;
		while (tx_busy && count < 3 * bit_clocks)
		begin
			@(posedge tb_clk);
			#1;
			count++;
		end
		if (tx_busy)
		begin
			$display("%s: tx_busy stayed high after the end of packet", test_name);
			timeouts++;
		end
		else if (count != bit_clocks + 1)
		begin
			$display("%s: tx_busy fell %0d clocks after the closing J instead of %0d",
				test_name, count, bit_clocks + 1);
			errors++;
		end
	endtask

	task check_idle_after_reset;
		test_name = "idle";
		repeat (4)
		begin
			check_line(1'b1, 1'b0);
			check_level("tx_empty", 1'b1);
			check_level("tx_busy", 1'b0);
			repeat (bit_clocks)
				@(posedge tb_clk);
			#1;
		end
	endtask

	task single_byte_packet;
		test_name = "single byte";
		pkt_bytes = '{8'h2C};
		run_packet();
	endtask

	// Runs of ones inside and across the two bytes
	task stuffing_packet;
		test_name = "stuffing";
		pkt_bytes = '{8'hFF, 8'h7F};
		run_packet();
	endtask

	task multi_byte_packet;
		logic [byte_width-1:0] value;
		test_name = "multi byte";
		pkt_bytes = '{8'h80};
		repeat (6)
		begin
			random_byte(value);
			pkt_bytes.push_back(value);
		end
		run_packet();
	endtask

	task reset_mid_packet;
		test_name = "mid packet reset";
		@(posedge tb_clk);
		#1;
		tx_byte = 8'hA5;
		tx_last = 1'b0;
		tx_load = 1'b1;
		@(posedge tb_clk);
		#1;
		tx_load = 1'b0;
		// Well into the first byte
		repeat (3 * bit_clocks + 2)
			@(posedge tb_clk);
		apply_reset();
		check_line(1'b1, 1'b0);
		check_level("tx_busy", 1'b0);
		check_level("tx_empty", 1'b1);
		test_name = "after reset";
		pkt_bytes = '{8'h80, 8'hC3};
		run_packet();
	endtask

	initial
	begin
		tb_clk = 1'b0;
		arst_n = 1'b1;
		tx_byte = '0;
		tx_load = 1'b0;
		tx_last = 1'b0;
		errors = 0;
		timeouts = 0;
		lfsr_state = 32'h094b_ae68;
		apply_reset();
		check_idle_after_reset();
		single_byte_packet();
		stuffing_packet();
		multi_byte_packet();
		reset_mid_packet();
		$display("Mismatches: %0d, timeouts: %0d", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// File: logic/usb_tx.sv
// USB full-speed transmit line path from byte producer to D+ and D-
`timescale 1ns/100ps

module usb_tx
(
	input  logic                              tb_clk,
	input  logic                              arst_n,
	input  logic [usb_tx_pkg::byte_width-1:0] tx_byte,
	input  logic                              tx_load,
	input  logic                              tx_last,
	output logic                              tx_empty,
	output logic                              tx_busy,
	output logic                              d_plus_out,
	output logic                              d_minus_out
);

	// Controller to encoder
	logic tx_shift;
	logic tx_out_bit;
	logic create_eop;
	// Encoder back to controller
	logic tx_hold;
	logic line_idle;

	// Byte pacing and end of packet request
	usb_tx_packet u_packet
	(
		.tb_clk     (tb_clk),
		.arst_n     (arst_n),
		.tx_byte    (tx_byte),
		.tx_load    (tx_load),
		.tx_last    (tx_last),
		.tx_hold    (tx_hold),
		.line_idle  (line_idle),
		.tx_empty   (tx_empty),
		.tx_busy    (tx_busy),
		.tx_shift   (tx_shift),
		.tx_out_bit (tx_out_bit),
		.create_eop (create_eop)
	);

	// Stuffing, NRZI and line drive
	usb_encoder u_encoder
	(
		.tb_clk      (tb_clk),
		.arst_n      (arst_n),
		.tx_out_bit  (tx_out_bit),
		.tx_shift    (tx_shift),
		.create_eop  (create_eop),
		.tx_hold     (tx_hold),
		.line_idle   (line_idle),
		.d_plus_out  (d_plus_out),
		.d_minus_out (d_minus_out)
	);

endmodule

// File: logic/usb_tx_packet.sv
// USB transmit packet controller that paces loaded bytes out as bus-rate bit strobes
`timescale 1ns/100ps

module usb_tx_packet
(
	input  logic                              tb_clk,
	input  logic                              arst_n,
	input  logic [usb_tx_pkg::byte_width-1:0] tx_byte,
	input  logic                              tx_load,
	input  logic                              tx_last,
	input  logic                              tx_hold,
	input  logic                              line_idle,
	output logic                              tx_empty,
	output logic                              tx_busy,
	output logic                              tx_shift,
	output logic                              tx_out_bit,
	output logic                              create_eop
);
	import usb_tx_pkg::*;

	// Current byte, bit 0 goes out first
	logic [byte_width-1:0] shift_reg;
	// Bits of the current byte not yet on the line
	logic [bits_left_width-1:0] bits_left;
	// Current byte closes the packet
	logic last_byte;
	// Position inside the bit period
	logic [bit_count_width-1:0] bit_count;
	// EOP handed to the encoder, waiting for the line to go idle
	logic eop_phase;
	// Scheduled strobe slot
	logic bit_time;
	logic load_ok;
	logic advance;

	// One slot per bit period while busy
	assign bit_time = tx_busy && (bit_count == bit_count_width'(bit_clocks - 1));

	// Out of bits in the data phase ends the packet
	// A pending stuffed zero still goes out first
	// Covers both the last byte and a producer underrun
	assign create_eop = bit_time && !eop_phase && (bits_left == '0) && !tx_hold;

	// EOP slot replaces the strobe
	assign tx_shift = bit_time && !create_eop;

	// Room for the next byte once the shift register has run dry
	// Closed while an EOP is pending or being issued
	assign tx_empty = !eop_phase && !last_byte && (bits_left == '0) && !create_eop;

	assign load_ok = tx_load && tx_empty;

	// Stuffed zeros and EOP strobes leave the byte alone
	assign advance = tx_shift && !tx_hold && !eop_phase;

	assign tx_out_bit = shift_reg[0];

	// Bit timer
	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tx_busy   <= 1'b0;
			bit_count <= '0;
		end
		else if (load_ok && !tx_busy)
		begin
			// First byte of a packet starts the bit grid
			tx_busy   <= 1'b1;
			bit_count <= '0;
		end
		else if (eop_phase && line_idle)
		begin
			tx_busy <= 1'b0;
		end
		else if (tx_busy)
		begin
			// Wraps every bit_clocks clocks
			bit_count <= bit_count + 1'b1;
		end
	end

	// End of packet tracking
	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			eop_phase <= 1'b0;
		end
		else if (create_eop)
		begin
			eop_phase <= 1'b1;
		end
		else if (line_idle)
		begin
			// Trailing J done
			eop_phase <= 1'b0;
		end
	end

	// Byte accounting
	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			bits_left <= '0;
			last_byte <= 1'b0;
		end
		else if (load_ok)
		begin
			// Later loads join the running grid
			bits_left <= bits_left_width'(byte_width);
			last_byte <= tx_last;
		end
		else if (advance)
		begin
			bits_left <= bits_left - 1'b1;
		end
		else if (create_eop)
		begin
			last_byte <= 1'b0;
		end
	end

	// Byte shifter
	always_ff @(posedge tb_clk)
	begin
		if (load_ok)
		begin
			shift_reg <= tx_byte;
		end
		else if (advance)
		begin
			shift_reg <= {1'b0, shift_reg[byte_width-1:1]};
		end
	end

	// Producer only loads into an empty buffer
	assert property (@(posedge tb_clk) disable iff (!arst_n) tx_load |-> tx_empty);

endmodule

// File: logic/usb_encoder.sv
// USB line encoder with bit stuffing, NRZI coding and end-of-packet drive
`timescale 1ns/100ps

module usb_encoder
(
	input  logic tb_clk,
	input  logic arst_n,
	input  logic tx_out_bit,
	input  logic tx_shift,
	input  logic create_eop,
	output logic tx_hold,
	output logic line_idle,
	output logic d_plus_out,
	output logic d_minus_out
);
	import usb_tx_pkg::*;

	// Ones sent in a row, across byte boundaries
	logic [ones_count_width-1:0] ones_count;
	// NRZI level, high is J
	logic nrzi_level;
	// SE0 part of the EOP
	logic se0_phase;
	// Closing J part of the EOP
	logic j_phase;
	// SE0 bit times already done
	logic [se0_count_width-1:0] se0_count;
	// Bit that the current strobe puts on the line
	logic data_bit;
	logic next_level;

	// Full run of ones forces a zero on the next strobe
	assign tx_hold = (ones_count == ones_count_width'(stuff_run));

	assign data_bit = tx_hold ? 1'b0 : tx_out_bit;

	// Zero toggles the line, one keeps it
	assign next_level = data_bit ? nrzi_level : !nrzi_level;

	always_ff @(posedge tb_clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			ones_count  <= '0;
			nrzi_level  <= 1'b1;
			se0_phase   <= 1'b0;
			j_phase     <= 1'b0;
			se0_count   <= '0;
			line_idle   <= 1'b1;
			d_plus_out  <= 1'b1;
			d_minus_out <= 1'b0;
		end
		else if (create_eop)
		begin
			// SE0 starts, next packet begins from J
			ones_count  <= '0;
			nrzi_level  <= 1'b1;
			se0_phase   <= 1'b1;
			se0_count   <= '0;
			line_idle   <= 1'b0;
			d_plus_out  <= 1'b0;
			d_minus_out <= 1'b0;
		end
		else if (tx_shift)
		begin
			if (se0_phase)
			begin
				if (se0_count == se0_count_width'(eop_se0_bits - 1))
				begin
					// SE0 over, one bit time of J
					se0_phase   <= 1'b0;
					j_phase     <= 1'b1;
					d_plus_out  <= 1'b1;
					d_minus_out <= 1'b0;
				end
				else
				begin
					se0_count <= se0_count + 1'b1;
				end
			end
			else if (j_phase)
			begin
				// Line stays at J from here on
				j_phase   <= 1'b0;
				line_idle <= 1'b1;
			end
			else
			begin
				line_idle   <= 1'b0;
				nrzi_level  <= next_level;
				d_plus_out  <= next_level;
				d_minus_out <= !next_level;
				if (data_bit)
				begin
					ones_count <= ones_count + 1'b1;
				end
				else
				begin
					// Stuffed or real zero ends the run
					ones_count <= '0;
				end
			end
		end
	end

	// No SE1 on the line
	assert property (@(posedge tb_clk) disable iff (!arst_n) !(d_plus_out && d_minus_out));

	// EOP has cleared the ones run before its SE0 strobes
	assert property (@(posedge tb_clk) disable iff (!arst_n)
		(tx_shift && se0_phase) |-> !tx_hold);

endmodule

// File: logic/usb_tx_pkg.sv
// USB transmit path bus timing and line coding constants
package usb_tx_pkg;

	// Bus timing

	// Clocks per full-speed bit time
	localparam int bit_clocks = 8;

	// Bit-period counter width, enough for bit_clocks states
	localparam int bit_count_width = 3;

	// Byte payload

	// Bits per producer byte
	localparam int byte_width = 8;

	// Count of bits still waiting in the shift register
	localparam int bits_left_width = 4;

	// Line coding

	// Ones in a row before a zero is stuffed
	localparam int stuff_run = 6;

	// Counter width for the ones run
	localparam int ones_count_width = 3;

	// Bit times of SE0 at the end of a packet
	localparam int eop_se0_bits = 2;

	// Counter width for the SE0 bit times
	localparam int se0_count_width = 2;

endpackage
